// File: vlog.f
+incdir+design
design/dmc_pkg.sv
design/dfi_cmd_if.sv
design/bridge_fifo.sv
design/dfi_cmd_decoder.sv
design/dfi_wrdata_capture.sv
design/axi_txn_issuer.sv
design/dfi_axi_bridge.sv
bench/bridge_checker.sv
bench/tb_dfi_axi_bridge.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator, then look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f vlog.f \
  --top-module tb_dfi_axi_bridge -o sim_tb > build.log 2>&1 &&
./obj_dir/sim_tb > sim.log 2>&1 ||
{ echo "build or simulation failed, see build.log and sim.log"; exit 1; }

grep -q '^\*\* PASS \*\*$' sim.log &&
echo "simulation passed" ||
{ echo "simulation failed, see sim.log"; exit 1; }

// File: bench/tb_dfi_axi_bridge.sv
`timescale 1ns/1ps
`include "dmc_consts.svh"

module tb_dfi_axi_bridge;

  typedef enum int {OP_ACT, OP_PRE, OP_WR, OP_RD} op_e;

  typedef struct {
    int          test;
    op_e         op;
    logic [2:0]  bank;
    logic [15:0] addr;
    logic [31:0] dlo;
    logic [31:0] dhi;
    logic [3:0]  mlo;
    logic [3:0]  mhi;
  } entry_s;

  logic        clk;
  logic        arst_n;
  logic [2:0]  dfi_bank;
  logic [15:0] dfi_address;
  logic        dfi_cs_n, dfi_ras_n, dfi_cas_n, dfi_we_n;
  logic        dfi_wrdata_en;
  logic [31:0] dfi_wrdata;
  logic [3:0]  dfi_wrdata_mask;
  logic [31:0] dfi_rddata;
  logic        dfi_rddata_valid;
  logic [31:0] awaddr, araddr;
  logic        awvalid, awready, wvalid, wready, bvalid, bready;
  logic [63:0] wdata, rdata;
  logic [7:0]  wstrb;
  logic        arvalid, arready, rvalid, rready;
  logic        error;
  int          err_cnt, chk_cnt, pending;
  entry_s      table_q [$];
  logic [63:0] slave_mem [logic [31:0]];
  logic        aw_got, w_got;
  logic [31:0] aw_addr;
  logic [63:0] w_data;
  logic [7:0]  w_strb;
  int          errs_before;
  logic        idle_ok;
  logic        timed_out;
  string       names [6];

  dfi_axi_bridge UUT
    (.dfi_clk_1x_i(clk), .arst_n_i(arst_n)
    ,.dfi_bank_i(dfi_bank), .dfi_address_i(dfi_address), .dfi_cs_n_i(dfi_cs_n)
    ,.dfi_ras_n_i(dfi_ras_n), .dfi_cas_n_i(dfi_cas_n), .dfi_we_n_i(dfi_we_n)
    ,.dfi_wrdata_en_i(dfi_wrdata_en), .dfi_wrdata_i(dfi_wrdata)
    ,.dfi_wrdata_mask_i(dfi_wrdata_mask), .dfi_rddata_o(dfi_rddata)
    ,.dfi_rddata_valid_o(dfi_rddata_valid)
    ,.axi_awaddr_o(awaddr), .axi_awvalid_o(awvalid), .axi_awready_i(awready)
    ,.axi_wdata_o(wdata), .axi_wstrb_o(wstrb), .axi_wvalid_o(wvalid), .axi_wready_i(wready)
    ,.axi_bvalid_i(bvalid), .axi_bready_o(bready)
    ,.axi_araddr_o(araddr), .axi_arvalid_o(arvalid), .axi_arready_i(arready)
    ,.axi_rdata_i(rdata), .axi_rvalid_i(rvalid), .axi_rready_o(rready)
    ,.error_o(error));

  bridge_checker chk
    (.clk_i(clk), .arst_n_i(arst_n)
    ,.dfi_bank_i(dfi_bank), .dfi_address_i(dfi_address), .dfi_cs_n_i(dfi_cs_n)
    ,.dfi_ras_n_i(dfi_ras_n), .dfi_cas_n_i(dfi_cas_n), .dfi_we_n_i(dfi_we_n)
    ,.dfi_wrdata_en_i(dfi_wrdata_en), .dfi_wrdata_i(dfi_wrdata)
    ,.dfi_wrdata_mask_i(dfi_wrdata_mask), .dfi_rddata_i(dfi_rddata)
    ,.dfi_rddata_valid_i(dfi_rddata_valid)
    ,.axi_awaddr_i(awaddr), .axi_awvalid_i(awvalid), .axi_awready_i(awready)
    ,.axi_wdata_i(wdata), .axi_wstrb_i(wstrb), .axi_wvalid_i(wvalid), .axi_wready_i(wready)
    ,.axi_bvalid_i(bvalid), .axi_bready_i(bready)
    ,.axi_araddr_i(araddr), .axi_arvalid_i(arvalid)
    ,.axi_arready_i(arready), .axi_rdata_i(rdata), .axi_rvalid_i(rvalid)
    ,.axi_rready_i(rready), .error_i(error)
    ,.err_cnt_o(err_cnt), .chk_cnt_o(chk_cnt), .pending_o(pending));

  always #4 clk = ~clk;

  // Unwritten words read back as a pattern of the whole address
  function automatic logic [63:0] slave_word(input logic [31:0] a);
    return slave_mem.exists(a) ? slave_mem[a] : {~a, a};
  endfunction

  // AXI slave memory with random ready delays
  always @(posedge clk or negedge arst_n) begin
    logic [63:0] merged;
    if (!arst_n) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      arready <= 1'b0;
      bvalid  <= 1'b0;
      rvalid  <= 1'b0;
      rdata   <= '0;
      aw_got = 1'b0;
      w_got  = 1'b0;
    end else begin
      awready <= ($urandom % 3) == 0;
      wready  <= ($urandom % 3) == 0;
      arready <= ($urandom % 3) == 0;
      if (awvalid && awready) begin
        aw_got = 1'b1;
        aw_addr = awaddr;
      end
      if (wvalid && wready) begin
        w_got = 1'b1;
        w_data = wdata;
        w_strb = wstrb;
      end
      if (bvalid && bready) bvalid <= 1'b0;
      if (aw_got && w_got) begin
        merged = slave_word(aw_addr);
        for (int i = 0; i < 8; i++) begin
          if (w_strb[i]) merged[i*8 +: 8] = w_data[i*8 +: 8];
        end
        slave_mem[aw_addr] = merged;
        aw_got = 1'b0;
        w_got  = 1'b0;
        bvalid <= 1'b1;
      end
      if (rvalid && rready) rvalid <= 1'b0;
      if (arvalid && arready) begin
        rvalid <= 1'b1;
        rdata  <= slave_word(araddr);
      end
    end
  end

  task automatic add(input int t, input op_e op, input logic [2:0] b, input logic [15:0] a,
                     input logic [31:0] dlo, input logic [31:0] dhi,
                     input logic [3:0] mlo, input logic [3:0] mhi);
    entry_s e;
    e = '{t, op, b, a, dlo, dhi, mlo, mhi};
    table_q.push_back(e);
  endtask

  task automatic apply_entry(input entry_s e);
    @(posedge clk);
    dfi_bank    <= e.bank;
    dfi_address <= e.addr;
    dfi_cs_n    <= 1'b0;
    dfi_ras_n   <= (e.op == OP_WR || e.op == OP_RD);
    dfi_cas_n   <= (e.op == OP_ACT || e.op == OP_PRE);
    dfi_we_n    <= (e.op == OP_ACT || e.op == OP_RD);
    @(posedge clk);
    dfi_cs_n <= 1'b1;
    if (e.op == OP_WR) begin
      dfi_wrdata_en   <= 1'b1;
      dfi_wrdata      <= e.dlo;
      dfi_wrdata_mask <= e.mlo;
      @(posedge clk);
      dfi_wrdata      <= e.dhi;
      dfi_wrdata_mask <= e.mhi;
      @(posedge clk);
      dfi_wrdata_en <= 1'b0;
    end
  endtask

  task automatic wait_idle(input int limit, output logic idle);
    int n;
    n = 0;
    @(negedge clk);
    while (pending != 0 && n < limit) begin
      @(negedge clk);
      n++;
    end
    idle = (pending == 0);
    if (!idle) begin
      $display("Timeout: AXI traffic still outstanding after %0d cycles", limit);
    end
  endtask

  initial begin
    void'($urandom(55717));
    clk = 1'b0;
    timed_out = 1'b0;
    arst_n <= 1'b0;
    dfi_bank <= '0;
    dfi_address <= '0;
    {dfi_cs_n, dfi_ras_n, dfi_cas_n, dfi_we_n} <= 4'b1111;
    dfi_wrdata_en <= 1'b0;
    dfi_wrdata <= '0;
    dfi_wrdata_mask <= '0;
    names = '{"", "reset values", "single write", "read back", "four writes", "closed bank"};

    add(2, OP_ACT, 3'd0, 16'h1234, 0, 0, 0, 0);
    add(2, OP_WR,  3'd0, 16'h0045, 32'h11223344, 32'h55667788, 4'b0010, 4'b1000);
    add(2, OP_ACT, 3'd1, 16'hbeef, 0, 0, 0, 0);
    add(2, OP_WR,  3'd1, 16'h03ff, 32'hcafef00d, 32'h0badc0de, 4'b0000, 4'b0000);
    add(3, OP_RD,  3'd1, 16'h03ff, 0, 0, 0, 0);
    for (int b = 2; b < 6; b++) add(4, OP_ACT, 3'(b), 16'(16'h0100 * b + 7), 0, 0, 0, 0);
    for (int b = 2; b < 6; b++) begin
      add(4, OP_WR, 3'(b), 16'(b * 3), 32'(32'ha5a50000 + b), 32'(32'h5a5a0000 + b), 0, 0);
    end
    add(5, OP_PRE, 3'd2, 16'h0000, 0, 0, 0, 0);
    add(5, OP_WR,  3'd2, 16'h0010, 32'hdeadbeef, 32'hfeedface, 0, 0);

    repeat (10) @(posedge clk);
    arst_n <= 1'b1;
    repeat (3) @(posedge clk);
    $display("test 1 %s: %s", names[1], err_cnt == 0 ? "passed" : "failed");

    for (int t = 2; t <= 5; t++) begin
      if (!timed_out) begin
        errs_before = err_cnt;
        foreach (table_q[i]) begin
          if (table_q[i].test == t) apply_entry(table_q[i]);
        end
        wait_idle(500, idle_ok);
        timed_out = !idle_ok;
        // Quiet window in which a stray AXI transaction would still be caught
        repeat (20) @(posedge clk);
        $display("test %0d %s: %s", t, names[t],
                 (idle_ok && err_cnt == errs_before) ? "passed" : "failed");
      end
    end

    $display("checks %0d, errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0 && !timed_out) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: bench/bridge_checker.sv
`timescale 1ns/1ps
`include "dmc_consts.svh"

module bridge_checker
  (input                               clk_i
  ,input                               arst_n_i
  ,input        [`BANK_WIDTH-1:0]      dfi_bank_i
  ,input        [`ROW_WIDTH-1:0]       dfi_address_i
  ,input                               dfi_cs_n_i
  ,input                               dfi_ras_n_i
  ,input                               dfi_cas_n_i
  ,input                               dfi_we_n_i
  ,input                               dfi_wrdata_en_i
  ,input        [`DFI_DATA_WIDTH-1:0]  dfi_wrdata_i
  ,input        [`DFI_MASK_WIDTH-1:0]  dfi_wrdata_mask_i
  ,input        [`DFI_DATA_WIDTH-1:0]  dfi_rddata_i
  ,input                               dfi_rddata_valid_i
  ,input        [`AXI_ADDR_WIDTH-1:0]  axi_awaddr_i
  ,input                               axi_awvalid_i
  ,input                               axi_awready_i
  ,input        [`AXI_DATA_WIDTH-1:0]  axi_wdata_i
  ,input        [`AXI_STRB_WIDTH-1:0]  axi_wstrb_i
  ,input                               axi_wvalid_i
  ,input                               axi_wready_i
  ,input                               axi_bvalid_i
  ,input                               axi_bready_i
  ,input        [`AXI_ADDR_WIDTH-1:0]  axi_araddr_i
  ,input                               axi_arvalid_i
  ,input                               axi_arready_i
  ,input        [`AXI_DATA_WIDTH-1:0]  axi_rdata_i
  ,input                               axi_rvalid_i
  ,input                               axi_rready_i
  ,input                               error_i
  ,output int                          err_cnt_o
  ,output int                          chk_cnt_o
  ,output int                          pending_o
  );

  logic    [`ROW_WIDTH-1:0] row_m [`NUM_BANKS];
  logic    [`NUM_BANKS-1:0] open_m;
  logic [`AXI_ADDR_WIDTH-1:0] exp_aw [$];
  logic [`AXI_ADDR_WIDTH-1:0] exp_ar [$];
  logic [`AXI_ADDR_WIDTH-1:0] exp_waddr [$];
  logic [`AXI_DATA_WIDTH-1:0] exp_wdata [$];
  logic [`AXI_STRB_WIDTH-1:0] exp_wstrb [$];
  logic [`AXI_DATA_WIDTH-1:0] mem_m [logic [`AXI_ADDR_WIDTH-1:0]];
  logic [`AXI_ADDR_WIDTH-1:0] cmd_addr;
  logic [`AXI_ADDR_WIDTH-1:0] rd_addr;
  logic [`AXI_ADDR_WIDTH-1:0] wa;
  logic [`AXI_DATA_WIDTH-1:0] ret_word;
  logic [`DFI_DATA_WIDTH-1:0] lo_data;
  logic [`DFI_MASK_WIDTH-1:0] lo_mask;
  logic                       beat_m;
  logic                       err_e0;
  logic                       err_e1;
  logic                       err_seen;
  logic                       rd_busy;
  logic                       seen_reset;
  int                         ret_step;
  int                         b_pend;

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] got);
    chk_cnt_o++;
    if (exp !== got) begin
      err_cnt_o++;
      $display("ERROR: %s expected %h got %h", name, exp, got);
    end
  endtask

  task automatic report_problem(input string what);
    err_cnt_o++;
    $display("Problem: %s", what);
  endtask

  initial begin
    err_cnt_o = 0;
    chk_cnt_o = 0;
    pending_o = 0;
  end

  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      open_m = '0;
      exp_aw.delete();
      exp_ar.delete();
      exp_waddr.delete();
      exp_wdata.delete();
      exp_wstrb.delete();
      beat_m = 1'b0;
      err_e0 = 1'b0;
      err_e1 = 1'b0;
      err_seen = 1'b0;
      rd_busy = 1'b0;
      ret_step = 0;
      b_pend = 0;
      seen_reset = 1'b0;
    end else begin
      if (!seen_reset) begin
        seen_reset = 1'b1;
        check_value("axi_awvalid_o", 0, axi_awvalid_i);
        check_value("axi_wvalid_o", 0, axi_wvalid_i);
        check_value("axi_arvalid_o", 0, axi_arvalid_i);
        check_value("axi_bready_o", 0, axi_bready_i);
        check_value("axi_rready_o", 0, axi_rready_i);
        check_value("dfi_rddata_valid_o", 0, dfi_rddata_valid_i);
      end
      // Sticky error shows two cycles after the bad command
      check_value("error_o", err_e1, error_i);
      err_seen = err_e1;
      err_e1 = err_e0;

      if (!dfi_cs_n_i) begin
        if (!dfi_ras_n_i && dfi_cas_n_i) begin
          if (dfi_we_n_i) begin
            row_m[dfi_bank_i] = dfi_address_i;
            open_m[dfi_bank_i] = 1'b1;
          end else begin
            open_m[dfi_bank_i] = 1'b0;
          end
        end else if (dfi_ras_n_i && !dfi_cas_n_i) begin
          if (!open_m[dfi_bank_i]) begin
            err_e0 = 1'b1;
          end else begin
            cmd_addr = {row_m[dfi_bank_i], dfi_bank_i, dfi_address_i[`COL_WIDTH-1:0], 3'b000};
            if (dfi_we_n_i) begin
              exp_ar.push_back(cmd_addr);
            end else begin
              exp_aw.push_back(cmd_addr);
              exp_waddr.push_back(cmd_addr);
              b_pend++;
            end
          end
        end
      end

      if (dfi_wrdata_en_i) begin
        if (!beat_m) begin
          lo_data = dfi_wrdata_i;
          lo_mask = dfi_wrdata_mask_i;
        end else begin
          exp_wdata.push_back({dfi_wrdata_i, lo_data});
          exp_wstrb.push_back(~{dfi_wrdata_mask_i, lo_mask});
        end
        beat_m = !beat_m;
      end

      if (axi_awvalid_i && axi_awready_i) begin
        if (exp_aw.size() == 0) report_problem("AXI write address with no write command queued");
        else check_value("axi_awaddr_o", exp_aw.pop_front(), axi_awaddr_i);
      end
      if (axi_wvalid_i && axi_wready_i) begin
        if (exp_wdata.size() == 0) begin
          report_problem("AXI write data with no DFI write beats seen");
        end else begin
          check_value("axi_wstrb_o", exp_wstrb[0], axi_wstrb_i);
          check_value("axi_wdata_o", exp_wdata[0], axi_wdata_i);
          if (exp_waddr.size() != 0) begin
            wa = exp_waddr.pop_front();
            // Partly written words are not tracked
            if (exp_wstrb[0] == '1) mem_m[wa] = exp_wdata[0];
            else mem_m.delete(wa);
          end
          void'(exp_wdata.pop_front());
          void'(exp_wstrb.pop_front());
        end
      end
      if (axi_bvalid_i && axi_bready_i) begin
        if (b_pend == 0) report_problem("AXI write response with no write outstanding");
        else b_pend--;
      end
      if (axi_arvalid_i && axi_arready_i) begin
        if (exp_ar.size() == 0) begin
          report_problem("AXI read address with no read command queued");
        end else begin
          rd_addr = exp_ar.pop_front();
          check_value("axi_araddr_o", rd_addr, axi_araddr_i);
          rd_busy = 1'b1;
        end
      end

      if (ret_step == 1) begin
        check_value("dfi_rddata_valid_o", 1, dfi_rddata_valid_i);
        check_value("dfi_rddata_o", ret_word[31:0], dfi_rddata_i);
        ret_step = 2;
      end else if (ret_step == 2) begin
        check_value("dfi_rddata_valid_o", 1, dfi_rddata_valid_i);
        check_value("dfi_rddata_o", ret_word[63:32], dfi_rddata_i);
        ret_step = 0;
        rd_busy = 1'b0;
      end else if (dfi_rddata_valid_i) begin
        report_problem("dfi_rddata_valid_o raised with no read returning");
      end
      if (axi_rvalid_i && axi_rready_i) begin
        ret_word = mem_m.exists(rd_addr) ? mem_m[rd_addr] : axi_rdata_i;
        ret_step = 1;
      end
    end
    pending_o = b_pend + exp_ar.size() + int'(rd_busy) + int'(err_e0 != err_seen);
  end

endmodule

// File: design/dfi_axi_bridge.sv
`timescale 1ns/1ps
`include "dmc_consts.svh"

module dfi_axi_bridge
  (input                               dfi_clk_1x_i
  ,input                               arst_n_i
  // DFI command
  ,input        [`BANK_WIDTH-1:0]      dfi_bank_i
  ,input        [`ROW_WIDTH-1:0]       dfi_address_i
  ,input                               dfi_cs_n_i
  ,input                               dfi_ras_n_i
  ,input                               dfi_cas_n_i
  ,input                               dfi_we_n_i
  // DFI write and read data
  ,input                               dfi_wrdata_en_i
  ,input        [`DFI_DATA_WIDTH-1:0]  dfi_wrdata_i
  ,input        [`DFI_MASK_WIDTH-1:0]  dfi_wrdata_mask_i
  ,output logic [`DFI_DATA_WIDTH-1:0]  dfi_rddata_o
  ,output logic                        dfi_rddata_valid_o
  // AXI write
  ,output logic [`AXI_ADDR_WIDTH-1:0]  axi_awaddr_o
  ,output logic                        axi_awvalid_o
  ,input                               axi_awready_i
  ,output logic [`AXI_DATA_WIDTH-1:0]  axi_wdata_o
  ,output logic [`AXI_STRB_WIDTH-1:0]  axi_wstrb_o
  ,output logic                        axi_wvalid_o
  ,input                               axi_wready_i
  ,input                               axi_bvalid_i
  ,output logic                        axi_bready_o
  // AXI read
  ,output logic [`AXI_ADDR_WIDTH-1:0]  axi_araddr_o
  ,output logic                        axi_arvalid_o
  ,input                               axi_arready_i
  ,input        [`AXI_DATA_WIDTH-1:0]  axi_rdata_i
  ,input                               axi_rvalid_i
  ,output logic                        axi_rready_o
  // Sticky error
  ,output logic                        error_o
  );

  dmc_pkg::mem_req_s req_in;
  dmc_pkg::mem_req_s req_out;
  dmc_pkg::wr_word_s word_in;
  dmc_pkg::wr_word_s word_out;
  logic              req_push;
  logic              req_pop;
  logic              req_empty;
  logic              req_ovf;
  logic              word_push;
  logic              word_pop;
  logic              word_empty;
  logic              word_ovf;
  logic              closed_bank_err;
  logic              error_q;

  dfi_cmd_if dfi_cmd ();

  assign dfi_cmd.bank    = dfi_bank_i;
  assign dfi_cmd.address = dfi_address_i;
  assign dfi_cmd.cs_n    = dfi_cs_n_i;
  assign dfi_cmd.ras_n   = dfi_ras_n_i;
  assign dfi_cmd.cas_n   = dfi_cas_n_i;
  assign dfi_cmd.we_n    = dfi_we_n_i;

  dfi_cmd_decoder cmd_decoder
    (.clk_i             ( dfi_clk_1x_i    )
    ,.arst_n_i          ( arst_n_i        )
    ,.dfi_cmd           ( dfi_cmd         )
    ,.req_push_o        ( req_push        )
    ,.req_o             ( req_in          )
    ,.closed_bank_err_o ( closed_bank_err ));

  dfi_wrdata_capture wrdata_capture
    (.clk_i         ( dfi_clk_1x_i      )
    ,.arst_n_i      ( arst_n_i          )
    ,.wrdata_en_i   ( dfi_wrdata_en_i   )
    ,.wrdata_i      ( dfi_wrdata_i      )
    ,.wrdata_mask_i ( dfi_wrdata_mask_i )
    ,.word_push_o   ( word_push         )
    ,.word_o        ( word_in           ));

  // DFI side has no back-pressure, so full only shows up as overflow
  bridge_fifo #
    (.payload_t ( dmc_pkg::mem_req_s )
    ,.depth_p   ( `QUEUE_DEPTH       ))
  req_fifo
    (.clk_i      ( dfi_clk_1x_i )
    ,.arst_n_i   ( arst_n_i     )
    ,.push_i     ( req_push     )
    ,.data_i     ( req_in       )
    ,.full_o     (              )
    ,.pop_i      ( req_pop      )
    ,.data_o     ( req_out      )
    ,.empty_o    ( req_empty    )
    ,.overflow_o ( req_ovf      ));

  bridge_fifo #
    (.payload_t ( dmc_pkg::wr_word_s )
    ,.depth_p   ( `QUEUE_DEPTH       ))
  data_fifo
    (.clk_i      ( dfi_clk_1x_i )
    ,.arst_n_i   ( arst_n_i     )
    ,.push_i     ( word_push    )
    ,.data_i     ( word_in      )
    ,.full_o     (              )
    ,.pop_i      ( word_pop     )
    ,.data_o     ( word_out     )
    ,.empty_o    ( word_empty   )
    ,.overflow_o ( word_ovf     ));

  axi_txn_issuer txn_issuer
    (.clk_i        ( dfi_clk_1x_i )
    ,.arst_n_i     ( arst_n_i     )
    ,.req_empty_i  ( req_empty    )
    ,.req_i        ( req_out      )
    ,.req_pop_o    ( req_pop      )
    ,.data_empty_i ( word_empty   )
    ,.data_i       ( word_out     )
    ,.data_pop_o   ( word_pop     )
    ,.axi_awaddr_o
    ,.axi_awvalid_o
    ,.axi_awready_i
    ,.axi_wdata_o
    ,.axi_wstrb_o
    ,.axi_wvalid_o
    ,.axi_wready_i
    ,.axi_bvalid_i
    ,.axi_bready_o
    ,.axi_araddr_o
    ,.axi_arvalid_o
    ,.axi_arready_i
    ,.axi_rdata_i
    ,.axi_rvalid_i
    ,.axi_rready_o
    ,.dfi_rddata_o
    ,.dfi_rddata_valid_o);

  // Held until reset
  always_ff @(posedge dfi_clk_1x_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      error_q <= 1'b0;
    end else if (closed_bank_err || req_ovf || word_ovf) begin
      error_q <= 1'b1;
    end
  end

  assign error_o = error_q;

endmodule

// File: design/axi_txn_issuer.sv
`timescale 1ns/1ps
`include "dmc_consts.svh"

module axi_txn_issuer
  (input                               clk_i
  ,input                               arst_n_i
  // Request queue
  ,input                               req_empty_i
  ,input  dmc_pkg::mem_req_s           req_i
  ,output logic                        req_pop_o
  // Write data queue
  ,input                               data_empty_i
  ,input  dmc_pkg::wr_word_s           data_i
  ,output logic                        data_pop_o
  // AXI write address and data
  ,output logic [`AXI_ADDR_WIDTH-1:0]  axi_awaddr_o
  ,output logic                        axi_awvalid_o
  ,input                               axi_awready_i
  ,output logic [`AXI_DATA_WIDTH-1:0]  axi_wdata_o
  ,output logic [`AXI_STRB_WIDTH-1:0]  axi_wstrb_o
  ,output logic                        axi_wvalid_o
  ,input                               axi_wready_i
  // AXI write response
  ,input                               axi_bvalid_i
  ,output logic                        axi_bready_o
  // AXI read address and data
  ,output logic [`AXI_ADDR_WIDTH-1:0]  axi_araddr_o
  ,output logic                        axi_arvalid_o
  ,input                               axi_arready_i
  ,input        [`AXI_DATA_WIDTH-1:0]  axi_rdata_i
  ,input                               axi_rvalid_i
  ,output logic                        axi_rready_o
  // Read return to DFI
  ,output logic [`DFI_DATA_WIDTH-1:0]  dfi_rddata_o
  ,output logic                        dfi_rddata_valid_o
  );

  typedef enum logic [2:0] {
    S_IDLE, S_WR_AW_W, S_WR_RESP, S_RD_ADDR, S_RD_DATA, S_RET_LO, S_RET_HI
  } state_e;

  state_e                     state_q;
  logic                       aw_pend_q;
  logic                       w_pend_q;
  logic [`AXI_ADDR_WIDTH-1:0] addr_q;
  logic [`AXI_DATA_WIDTH-1:0] wdata_q;
  logic [`AXI_STRB_WIDTH-1:0] wstrb_q;
  logic [`AXI_DATA_WIDTH-1:0] rdata_q;
  logic                       start_wr;
  logic                       start_rd;
  logic                       aw_done;
  logic                       w_done;

  // Writes need their data word queued too
  assign start_wr = (state_q == S_IDLE) && !req_empty_i
                    && (req_i.op == dmc_pkg::MEM_WRITE) && !data_empty_i;
  assign start_rd = (state_q == S_IDLE) && !req_empty_i
                    && (req_i.op == dmc_pkg::MEM_READ);

  assign req_pop_o  = start_wr || start_rd;
  assign data_pop_o = start_wr;

  assign aw_done = !aw_pend_q || axi_awready_i;
  assign w_done  = !w_pend_q || axi_wready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= S_IDLE;
      aw_pend_q <= 1'b0;
      w_pend_q  <= 1'b0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (start_wr) begin
            aw_pend_q <= 1'b1;
            w_pend_q  <= 1'b1;
            state_q   <= S_WR_AW_W;
          end else if (start_rd) begin
            state_q <= S_RD_ADDR;
          end
        end
        S_WR_AW_W: begin
          // AW and W channels complete independently
          if (axi_awready_i) aw_pend_q <= 1'b0;
          if (axi_wready_i)  w_pend_q  <= 1'b0;
          if (aw_done && w_done) state_q <= S_WR_RESP;
        end
        S_WR_RESP: if (axi_bvalid_i)  state_q <= S_IDLE;
        S_RD_ADDR: if (axi_arready_i) state_q <= S_RD_DATA;
        S_RD_DATA: if (axi_rvalid_i)  state_q <= S_RET_LO;
        S_RET_LO:  state_q <= S_RET_HI;
        S_RET_HI:  state_q <= S_IDLE;
        default:   state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_wr || start_rd) begin
      addr_q <= req_i.addr;
    end
    if (start_wr) begin
      wdata_q <= data_i.data;
      wstrb_q <= data_i.strb;
    end
    if ((state_q == S_RD_DATA) && axi_rvalid_i) begin
      rdata_q <= axi_rdata_i;
    end
  end

  assign axi_awaddr_o  = addr_q;
  assign axi_awvalid_o = aw_pend_q;
  assign axi_wdata_o   = wdata_q;
  assign axi_wstrb_o   = wstrb_q;
  assign axi_wvalid_o  = w_pend_q;
  assign axi_bready_o  = (state_q == S_WR_RESP);
  assign axi_araddr_o  = addr_q;
  assign axi_arvalid_o = (state_q == S_RD_ADDR);
  assign axi_rready_o  = (state_q == S_RD_DATA);

  // Low half first, then high half
  assign dfi_rddata_valid_o = (state_q == S_RET_LO) || (state_q == S_RET_HI);
  assign dfi_rddata_o = (state_q == S_RET_HI) ? rdata_q[`AXI_DATA_WIDTH-1:`DFI_DATA_WIDTH]
                                              : rdata_q[`DFI_DATA_WIDTH-1:0];

  awvalid_hold_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    axi_awvalid_o && !axi_awready_i |=> axi_awvalid_o && $stable(axi_awaddr_o))
    else $error("axi_txn_issuer: awvalid dropped before awready");

  arvalid_hold_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    axi_arvalid_o && !axi_arready_i |=> axi_arvalid_o && $stable(axi_araddr_o))
    else $error("axi_txn_issuer: arvalid dropped before arready");

endmodule

// File: design/dfi_wrdata_capture.sv
`timescale 1ns/1ps
`include "dmc_consts.svh"

module dfi_wrdata_capture
  (input                               clk_i
  ,input                               arst_n_i
  ,input                               wrdata_en_i
  ,input        [`DFI_DATA_WIDTH-1:0]  wrdata_i
  ,input        [`DFI_MASK_WIDTH-1:0]  wrdata_mask_i
  ,output logic                        word_push_o
  ,output dmc_pkg::wr_word_s           word_o
  );

  logic                       beat_q;
  logic [`DFI_DATA_WIDTH-1:0] half_data_q;
  logic [`DFI_MASK_WIDTH-1:0] half_strb_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      beat_q      <= 1'b0;
      word_push_o <= 1'b0;
    end else begin
      if (wrdata_en_i) begin
        beat_q <= !beat_q;
      end
      word_push_o <= wrdata_en_i && beat_q;
    end
  end

  // Mask bit set means byte not written
  always_ff @(posedge clk_i) begin
    if (wrdata_en_i && !beat_q) begin
      half_data_q <= wrdata_i;
      half_strb_q <= ~wrdata_mask_i;
    end
    if (wrdata_en_i && beat_q) begin
      word_o.data <= {wrdata_i, half_data_q};
      word_o.strb <= {~wrdata_mask_i, half_strb_q};
    end
  end

endmodule

// File: design/dfi_cmd_decoder.sv
`timescale 1ns/1ps
`include "dmc_consts.svh"

module dfi_cmd_decoder
  (input                         clk_i
  ,input                         arst_n_i
  ,dfi_cmd_if.decoder            dfi_cmd
  ,output logic                  req_push_o
  ,output dmc_pkg::mem_req_s     req_o
  ,output logic                  closed_bank_err_o
  );

  logic   [`ROW_WIDTH-1:0] row_q [`NUM_BANKS];
  logic   [`NUM_BANKS-1:0] open_q;
  logic  [`BANK_WIDTH-1:0] bank;
  logic   [`COL_WIDTH-1:0] col;
  logic                    cmd_act;
  logic                    cmd_pre;
  logic                    cmd_wr;
  logic                    cmd_rd;
  logic                    bank_open;

  assign bank = dfi_cmd.bank;
  assign col  = dfi_cmd.address[`COL_WIDTH-1:0];

  // Refresh, ZQ and self-refresh fall through all four patterns
  assign cmd_act = !dfi_cmd.cs_n && !dfi_cmd.ras_n &&  dfi_cmd.cas_n &&  dfi_cmd.we_n;
  assign cmd_pre = !dfi_cmd.cs_n && !dfi_cmd.ras_n &&  dfi_cmd.cas_n && !dfi_cmd.we_n;
  assign cmd_wr  = !dfi_cmd.cs_n &&  dfi_cmd.ras_n && !dfi_cmd.cas_n && !dfi_cmd.we_n;
  assign cmd_rd  = !dfi_cmd.cs_n &&  dfi_cmd.ras_n && !dfi_cmd.cas_n &&  dfi_cmd.we_n;

  assign bank_open = open_q[bank];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      open_q            <= '0;
      req_push_o        <= 1'b0;
      closed_bank_err_o <= 1'b0;
    end else begin
      if (cmd_act) begin
        open_q[bank] <= 1'b1;
      end else if (cmd_pre) begin
        open_q[bank] <= 1'b0;
      end
      req_push_o        <= (cmd_wr || cmd_rd) && bank_open;
      closed_bank_err_o <= (cmd_wr || cmd_rd) && !bank_open;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_act) begin
      row_q[bank] <= dfi_cmd.address;
    end
  end

  // Row, bank, column, then the byte offset
  always_ff @(posedge clk_i) begin
    if (cmd_wr || cmd_rd) begin
      req_o.op   <= cmd_rd ? dmc_pkg::MEM_READ : dmc_pkg::MEM_WRITE;
      req_o.addr <= {row_q[bank], bank, col, {`ADDR_LSB_ZEROS{1'b0}}};
    end
  end

  // Controller keeps tRCD, so a column command never follows ACT directly
  act_to_cas_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    cmd_act |=> !((cmd_wr || cmd_rd) && (dfi_cmd.bank == $past(dfi_cmd.bank))))
    else $error("dfi_cmd_decoder: WR/RD on the cycle after ACT to bank %0d", bank);

endmodule

// File: design/bridge_fifo.sv
`timescale 1ns/1ps

module bridge_fifo
 #(parameter type payload_t = logic
  ,parameter int  depth_p   = 4)
  (input                   clk_i
  ,input                   arst_n_i
  ,input                   push_i
  ,input  payload_t        data_i
  ,output logic            full_o
  ,input                   pop_i
  ,output payload_t        data_o
  ,output logic            empty_o
  ,output logic            overflow_o
  );

  localparam int ptr_width_lp   = (depth_p > 1) ? $clog2(depth_p) : 1;
  localparam int count_width_lp = $clog2(depth_p + 1);

  payload_t                  mem_q [depth_p];
  logic   [ptr_width_lp-1:0] wr_ptr_q;
  logic   [ptr_width_lp-1:0] rd_ptr_q;
  logic [count_width_lp-1:0] count_q;
  logic                      do_push;
  logic                      do_pop;

  assign full_o     = (count_q == count_width_lp'(depth_p));
  assign empty_o    = (count_q == '0);
  assign do_push    = push_i && !full_o;
  assign do_pop     = pop_i && !empty_o;
  // A push into a full queue is lost
  assign overflow_o = push_i && full_o;
  assign data_o     = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_width_lp'(depth_p - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_width_lp'(depth_p - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Consumer must look at empty before popping
  pop_not_empty_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    pop_i |-> !empty_o)
    else $error("bridge_fifo: pop while empty");

endmodule

// File: design/dfi_cmd_if.sv
`timescale 1ns/1ps
`include "dmc_consts.svh"

interface dfi_cmd_if;

  logic [`BANK_WIDTH-1:0] bank;
  logic  [`ROW_WIDTH-1:0] address;
  logic                   cs_n;
  logic                   ras_n;
  logic                   cas_n;
  logic                   we_n;

  modport decoder (input bank, address, cs_n, ras_n, cas_n, we_n);

  modport source (output bank, address, cs_n, ras_n, cas_n, we_n);

endinterface

// File: design/dmc_pkg.sv
`include "dmc_consts.svh"

package dmc_pkg;

  // Kind of a queued memory request
  typedef enum logic {
    MEM_WRITE = 1'b0,
    MEM_READ  = 1'b1
  } mem_op_e;

  // Request queue entry, op plus AXI byte address
  typedef struct packed {
    mem_op_e                    op;
    logic [`AXI_ADDR_WIDTH-1:0] addr;
  } mem_req_s;

  // Write data queue entry
  typedef struct packed {
    logic [`AXI_DATA_WIDTH-1:0] data;
    logic [`AXI_STRB_WIDTH-1:0] strb;
  } wr_word_s;

endpackage

// File: design/dmc_consts.svh
`ifndef DMC_CONSTS_SVH
`define DMC_CONSTS_SVH

// DDR data pins and the DFI beat built from them
`define DQ_WIDTH        16
`define DFI_DATA_WIDTH  (2 * `DQ_WIDTH)
`define DFI_MASK_WIDTH  (`DFI_DATA_WIDTH / 8)

// One AXI word per DFI burst
`define BURST_BEATS     2
`define AXI_DATA_WIDTH  (`DFI_DATA_WIDTH * `BURST_BEATS)
`define AXI_STRB_WIDTH  (`AXI_DATA_WIDTH / 8)
`define AXI_ADDR_WIDTH  32

// DFI command address fields
`define BANK_WIDTH      3
`define NUM_BANKS       (1 << `BANK_WIDTH)
`define ROW_WIDTH       16
`define COL_WIDTH       10

// Byte offset within one AXI word, always zero
`define ADDR_LSB_ZEROS  3

`define QUEUE_DEPTH     4

`endif
